//--- logic/roce_pkg.sv
package roce_pkg;

  // WQE opcodes as written by the host driver
  localparam logic [7:0] wqe_op_write = 8'h00;
  localparam logic [7:0] wqe_op_send  = 8'h02;
  localparam logic [7:0] wqe_op_read  = 8'h04;

  // RC transport opcodes
  typedef enum logic [7:0] {
    SEND_FIRST   = 8'h00,
    SEND_MIDDLE  = 8'h01,
    SEND_LAST    = 8'h02,
    SEND_ONLY    = 8'h04,
    WRITE_FIRST  = 8'h06,
    WRITE_MIDDLE = 8'h07,
    WRITE_LAST   = 8'h08,
    WRITE_ONLY   = 8'h0A,
    READ_REQUEST = 8'h0C
  } rc_opcode_t;

  typedef logic [31:0] len_t;
  typedef logic [23:0] qpn_t;

  // MTU is 256 << code, codes 0..4
  typedef logic [2:0] mtu_code_t;

  // 64-byte WQE as it sits in host memory
  typedef struct packed {
    logic [287:0] rsvd_hi;
    logic [63:0]  remote_vaddr;
    logic [23:0]  rsvd_mid;
    logic [7:0]   opcode;
    len_t         length;
    logic [79:0]  rsvd_lo;
    logic [15:0]  wr_id;
  } wqe_fields_t;

  typedef union packed {
    logic [511:0] raw;
    wqe_fields_t  f;
  } wqe_word_t;

  typedef enum logic [1:0] {
    op_write,
    op_send,
    op_read,
    op_bad
  } op_class_t;

endpackage

//--- logic/host_mem_pkg.sv
package host_mem_pkg;

  typedef logic [63:0] addr_t;

  localparam int axi_data_w = 512;

  // Log2 of the element size, also used as AXI size
  localparam logic [2:0] wqe_size_log2 = 3'd6;
  localparam logic [2:0] cqe_size_log2 = 3'd2;

  localparam logic [1:0] axi_burst_incr = 2'b01;

  // Completion queue entry
  typedef struct packed {
    logic [7:0]  status;
    logic [7:0]  opcode;
    logic [15:0] wr_id;
  } cqe_t;

  localparam logic [7:0] cqe_ok     = 8'd0;
  localparam logic [7:0] cqe_bad_op = 8'd1;

endpackage

//--- logic/sq_if.sv
`timescale 1ns/1ps

// Fetched WQE plus its queue context, held until completion
interface wqe_if
  import roce_pkg::*;
  import host_mem_pkg::*;
#(
  parameter int NUM_SQ = 8
) ();
  logic                      start;
  wqe_word_t                 wqe;
  logic [$clog2(NUM_SQ)-1:0] sq_idx;
  logic [31:0]               wqe_idx;
  addr_t                     pd_vaddr;
  addr_t                     cq_base;
  mtu_code_t                 mtu_code;

  modport src (output start, wqe, sq_idx, wqe_idx, pd_vaddr, cq_base, mtu_code);
  modport dst (input start, wqe, sq_idx, wqe_idx, pd_vaddr, cq_base, mtu_code);
endinterface

interface cmpl_if
  import roce_pkg::*;
();
  logic        all_sent;
  logic [31:0] exp_cnt;
  logic [7:0]  status;
  op_class_t   op_class;
  logic        done;

  modport src (output all_sent, exp_cnt, status, op_class, input done);
  modport dst (input all_sent, exp_cnt, status, op_class, output done);
endinterface

//--- logic/wqe_fetch.sv
`timescale 1ns/1ps

module wqe_fetch
  import roce_pkg::*;
  import host_mem_pkg::*;
#(
  parameter int NUM_SQ = 8,
  localparam int SQ_W = $clog2(NUM_SQ)
) (
  input  logic                  axis_aclk_i,
  input  logic                  axis_rstn_i,
  input  logic [SQ_W-1:0]       sq_idx_i,
  input  logic [31:0]           sq_pi_i,
  input  addr_t                 sq_base_i,
  input  addr_t                 cq_base_i,
  input  addr_t                 pd_vaddr_i,
  input  logic [31:0]           qp_conf_i,
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output addr_t                 ar_addr_o,
  output logic [2:0]            ar_size_o,
  input  logic                  r_valid_i,
  output logic                  r_ready_o,
  input  logic [axi_data_w-1:0] r_data_i,
  input  logic                  r_last_i,
  wqe_if.src                    wqe_o,
  input  logic                  done_i,
  output logic [39:0]           cq_head_o,
  output logic                  cq_head_valid_o
);

  typedef enum logic [2:0] {
    s_idle,
    s_ar,
    s_r,
    s_start,
    s_busy,
    s_head
  } fetch_state_t;

  fetch_state_t    state_q;
  logic [31:0]     pi_q  [NUM_SQ];
  logic [31:0]     idx_q [NUM_SQ];
  logic [SQ_W-1:0] cur_q;
  logic [31:0]     cur_idx;
  logic            db_hit;
  addr_t           sq_base_q;
  addr_t           cq_base_q;
  addr_t           pd_vaddr_q;
  addr_t           ar_addr_q;
  mtu_code_t       mtu_q;
  wqe_word_t       wqe_q;

  assign cur_idx = idx_q[cur_q];

  // Level doorbell, only for an enabled QP with a legal MTU
  assign db_hit = (state_q == s_idle) && (sq_pi_i > pi_q[sq_idx_i]) &&
                  qp_conf_i[0] && (qp_conf_i[10:8] <= 3'd4);

  //////////////////////////////////////////////////////////////////////
  // Fetch sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= s_idle;
      cur_q   <= '0;
      for (int i = 0; i < NUM_SQ; i++) begin
        pi_q[i]  <= '0;
        idx_q[i] <= '0;
      end
    end else begin
      case (state_q)
        s_idle: begin
          if (db_hit) begin
            cur_q          <= sq_idx_i;
            pi_q[sq_idx_i] <= sq_pi_i;
            state_q        <= s_ar;
          end
        end
        s_ar: begin
          if (ar_ready_i) begin
            state_q <= s_r;
          end
        end
        s_r: begin
          if (r_valid_i && r_last_i) begin
            state_q <= s_start;
          end
        end
        s_start: begin
          state_q <= s_busy;
        end
        s_busy: begin
          if (done_i) begin
            idx_q[cur_q] <= cur_idx + 32'd1;
            state_q      <= s_head;
          end
        end
        s_head: begin
          // Keep draining this queue while entries are pending
          state_q <= (cur_idx < pi_q[cur_q]) ? s_ar : s_idle;
        end
        default: begin
          state_q <= s_idle;
        end
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (db_hit) begin
      sq_base_q  <= sq_base_i;
      cq_base_q  <= cq_base_i;
      pd_vaddr_q <= pd_vaddr_i;
      mtu_q      <= qp_conf_i[10:8];
      ar_addr_q  <= sq_base_i + (addr_t'(idx_q[sq_idx_i]) << wqe_size_log2);
    end else if (state_q == s_head) begin
      ar_addr_q <= sq_base_q + (addr_t'(cur_idx) << wqe_size_log2);
    end
    if ((state_q == s_r) && r_valid_i) begin
      wqe_q.raw <= r_data_i;
    end
  end

  assign ar_valid_o = (state_q == s_ar);
  assign ar_addr_o  = ar_addr_q;
  assign ar_size_o  = wqe_size_log2;
  assign r_ready_o  = (state_q == s_r);

  assign cq_head_valid_o = (state_q == s_head);
  assign cq_head_o       = {8'(cur_q), cur_idx};

  assign wqe_o.start    = (state_q == s_start);
  assign wqe_o.wqe      = wqe_q;
  assign wqe_o.sq_idx   = cur_q;
  assign wqe_o.wqe_idx  = cur_idx;
  assign wqe_o.pd_vaddr = pd_vaddr_q;
  assign wqe_o.cq_base  = cq_base_q;
  assign wqe_o.mtu_code = mtu_q;

endmodule

//--- logic/req_segmenter.sv
`timescale 1ns/1ps

module req_segmenter
  import roce_pkg::*;
  import host_mem_pkg::*;
(
  input  logic       axis_aclk_i,
  input  logic       axis_rstn_i,
  wqe_if.dst         wqe_i,
  output logic       req_valid_o,
  input  logic       req_ready_i,
  output rc_opcode_t req_opcode_o,
  output qpn_t       req_qpn_o,
  output logic       req_last_o,
  output addr_t      req_laddr_o,
  output addr_t      req_raddr_o,
  output len_t       req_len_o,
  cmpl_if.src        cmpl_o
);

  typedef enum logic [1:0] {
    s_idle,
    s_issue,
    s_sent
  } seg_state_t;

  seg_state_t  state_q;
  op_class_t   cls;
  len_t        len;
  len_t        mtu;
  len_t        rem_q;
  len_t        src_rem;
  len_t        seg_len;
  addr_t       la_q;
  addr_t       ra_q;
  addr_t       src_la;
  addr_t       src_ra;
  addr_t       first_ra;
  logic        src_first;
  logic        seg_last;
  logic        load;
  rc_opcode_t  seg_op;
  logic [31:0] seg_cnt;

  assign len = wqe_i.wqe.f.length;
  assign mtu = len_t'(256) << wqe_i.mtu_code;

  always_comb begin
    case (wqe_i.wqe.f.opcode)
      wqe_op_write: cls = op_write;
      wqe_op_send:  cls = op_send;
      wqe_op_read:  cls = op_read;
      default:      cls = op_bad;
    endcase
  end

  // Sends target the local buffer on both sides
  assign first_ra = (cls == op_send) ? wqe_i.pd_vaddr : wqe_i.wqe.f.remote_vaddr;

  // First segment comes from the WQE, the rest from the running registers
  assign src_first = (state_q == s_idle);
  assign src_rem   = src_first ? len : rem_q;
  assign src_la    = src_first ? wqe_i.pd_vaddr : la_q;
  assign src_ra    = src_first ? first_ra : ra_q;

  always_comb begin
    seg_last = (src_rem <= mtu) || (cls == op_read);
    seg_len  = seg_last ? src_rem : mtu;
    if (cls == op_read) begin
      seg_op = READ_REQUEST;
    end else if (cls == op_send) begin
      if (src_first) begin
        seg_op = seg_last ? SEND_ONLY : SEND_FIRST;
      end else begin
        seg_op = seg_last ? SEND_LAST : SEND_MIDDLE;
      end
    end else begin
      if (src_first) begin
        seg_op = seg_last ? WRITE_ONLY : WRITE_FIRST;
      end else begin
        seg_op = seg_last ? WRITE_LAST : WRITE_MIDDLE;
      end
    end
  end

  assign load = (src_first && wqe_i.start && (cls != op_bad)) ||
                ((state_q == s_issue) && req_ready_i && !req_last_o);

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= s_idle;
    end else begin
      case (state_q)
        s_idle: begin
          if (wqe_i.start) begin
            state_q <= (cls == op_bad) ? s_sent : s_issue;
          end
        end
        s_issue: begin
          if (req_ready_i && req_last_o) begin
            state_q <= s_sent;
          end
        end
        s_sent: begin
          if (cmpl_o.done) begin
            state_q <= s_idle;
          end
        end
        default: begin
          state_q <= s_idle;
        end
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (load) begin
      req_opcode_o <= seg_op;
      req_last_o   <= seg_last;
      req_len_o    <= seg_len;
      req_laddr_o  <= src_la;
      req_raddr_o  <= src_ra;
      rem_q        <= src_rem - seg_len;
      la_q         <= src_la + addr_t'(mtu);
      ra_q         <= src_ra + addr_t'(mtu);
    end
  end

  assign req_valid_o = (state_q == s_issue);
  assign req_qpn_o   = qpn_t'(wqe_i.sq_idx);

  // Responses expected, ceil(len / mtu)
  assign seg_cnt = ((len >> 8) >> wqe_i.mtu_code) + {31'd0, |(len & (mtu - len_t'(1)))};

  assign cmpl_o.all_sent = (state_q == s_sent);
  assign cmpl_o.op_class = cls;
  assign cmpl_o.status   = (cls == op_bad) ? cqe_bad_op : cqe_ok;
  assign cmpl_o.exp_cnt  = (cls == op_bad) ? 32'd0 :
                           (seg_cnt == 32'd0) ? 32'd1 : seg_cnt;

endmodule

//--- logic/resp_tracker.sv
`timescale 1ns/1ps

module resp_tracker
  import roce_pkg::*;
(
  input  logic        axis_aclk_i,
  input  logic        axis_rstn_i,
  input  logic        rx_ack_i,
  input  logic        rx_nack_i,
  input  logic        rx_dat_i,
  input  op_class_t   op_class_i,
  input  logic        done_i,
  output logic [31:0] resp_cnt_o
);

  logic hit;

  // Writes and sends are acked, reads answered with data
  assign hit = (rx_ack_i && ((op_class_i == op_write) || (op_class_i == op_send))) ||
               (rx_dat_i && (op_class_i == op_read));

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      resp_cnt_o <= '0;
    end else if (rx_nack_i || done_i) begin
      resp_cnt_o <= '0;
    end else if (hit) begin
      resp_cnt_o <= resp_cnt_o + 32'd1;
    end
  end

endmodule

//--- logic/cqe_writer.sv
`timescale 1ns/1ps

module cqe_writer
  import host_mem_pkg::*;
(
  input  logic                      axis_aclk_i,
  input  logic                      axis_rstn_i,
  wqe_if.dst                        wqe_i,
  cmpl_if.dst                       cmpl_i,
  input  logic [31:0]               resp_cnt_i,
  output logic                      aw_valid_o,
  input  logic                      aw_ready_i,
  output addr_t                     aw_addr_o,
  output logic [2:0]                aw_size_o,
  output logic                      w_valid_o,
  input  logic                      w_ready_i,
  output logic [axi_data_w-1:0]     w_data_o,
  output logic [axi_data_w/8-1:0]   w_strb_o,
  output logic                      w_last_o,
  input  logic                      b_valid_i,
  output logic                      b_ready_o
);

  typedef enum logic [2:0] {
    s_idle,
    s_aw,
    s_w,
    s_b,
    s_done
  } wr_state_t;

  wr_state_t state_q;
  logic      cnt_met;
  addr_t     aw_addr_q;
  cqe_t      cqe_q;

  assign cnt_met = cmpl_i.all_sent && (resp_cnt_i == cmpl_i.exp_cnt);

  //////////////////////////////////////////////////////////////////////
  // AW, W, B in strict order
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= s_idle;
    end else begin
      case (state_q)
        s_idle: begin
          if (cnt_met) begin
            state_q <= s_aw;
          end
        end
        s_aw: begin
          if (aw_ready_i) begin
            state_q <= s_w;
          end
        end
        s_w: begin
          if (w_ready_i) begin
            state_q <= s_b;
          end
        end
        s_b: begin
          if (b_valid_i) begin
            state_q <= s_done;
          end
        end
        default: begin
          state_q <= s_idle;
        end
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if ((state_q == s_idle) && cnt_met) begin
      aw_addr_q    <= wqe_i.cq_base + (addr_t'(wqe_i.wqe_idx) << cqe_size_log2);
      cqe_q.wr_id  <= wqe_i.wqe.f.wr_id;
      cqe_q.opcode <= wqe_i.wqe.f.opcode;
      cqe_q.status <= cmpl_i.status;
    end
  end

  assign aw_valid_o = (state_q == s_aw);
  assign aw_addr_o  = aw_addr_q;
  assign aw_size_o  = cqe_size_log2;

  // CQE sits in the low lanes of a single beat
  assign w_valid_o = (state_q == s_w);
  assign w_data_o  = axi_data_w'(cqe_q);
  assign w_strb_o  = {{(axi_data_w/8-4){1'b0}}, 4'hF};
  assign w_last_o  = 1'b1;
  assign b_ready_o = 1'b1;

  assign cmpl_i.done = (state_q == s_done);

endmodule

//--- logic/sq_engine_top.sv
`timescale 1ns/1ps

module sq_engine_top
  import roce_pkg::*;
  import host_mem_pkg::*;
#(
  parameter int NUM_SQ = 8,
  localparam int SQ_W = $clog2(NUM_SQ)
) (
  input  logic                    axis_aclk_i,
  input  logic                    axis_rstn_i,
  input  logic [SQ_W-1:0]         sq_idx_i,
  input  logic [31:0]             sq_pi_i,
  input  addr_t                   sq_base_i,
  input  addr_t                   cq_base_i,
  input  addr_t                   pd_vaddr_i,
  input  logic [31:0]             qp_conf_i,
  input  logic                    rx_ack_i,
  input  logic                    rx_nack_i,
  input  logic                    rx_dat_i,
  output logic                    req_valid_o,
  input  logic                    req_ready_i,
  output rc_opcode_t              req_opcode_o,
  output qpn_t                    req_qpn_o,
  output logic                    req_last_o,
  output addr_t                   req_laddr_o,
  output addr_t                   req_raddr_o,
  output len_t                    req_len_o,
  output logic                    ar_valid_o,
  input  logic                    ar_ready_i,
  output addr_t                   ar_addr_o,
  output logic [2:0]              ar_size_o,
  input  logic                    r_valid_i,
  output logic                    r_ready_o,
  input  logic [axi_data_w-1:0]   r_data_i,
  input  logic                    r_last_i,
  output logic                    aw_valid_o,
  input  logic                    aw_ready_i,
  output addr_t                   aw_addr_o,
  output logic [2:0]              aw_size_o,
  output logic                    w_valid_o,
  input  logic                    w_ready_i,
  output logic [axi_data_w-1:0]   w_data_o,
  output logic [axi_data_w/8-1:0] w_strb_o,
  output logic                    w_last_o,
  input  logic                    b_valid_i,
  output logic                    b_ready_o,
  output logic [39:0]             cq_head_o,
  output logic                    cq_head_valid_o
);

  wqe_if #(.NUM_SQ(NUM_SQ)) wqe_bus ();
  cmpl_if cmpl_bus ();

  logic [31:0] resp_cnt;

  wqe_fetch #(
    .NUM_SQ(NUM_SQ)
  ) u_fetch (
    .axis_aclk_i     (axis_aclk_i),
    .axis_rstn_i     (axis_rstn_i),
    .sq_idx_i        (sq_idx_i),
    .sq_pi_i         (sq_pi_i),
    .sq_base_i       (sq_base_i),
    .cq_base_i       (cq_base_i),
    .pd_vaddr_i      (pd_vaddr_i),
    .qp_conf_i       (qp_conf_i),
    .ar_valid_o      (ar_valid_o),
    .ar_ready_i      (ar_ready_i),
    .ar_addr_o       (ar_addr_o),
    .ar_size_o       (ar_size_o),
    .r_valid_i       (r_valid_i),
    .r_ready_o       (r_ready_o),
    .r_data_i        (r_data_i),
    .r_last_i        (r_last_i),
    .wqe_o           (wqe_bus.src),
    .done_i          (cmpl_bus.done),
    .cq_head_o       (cq_head_o),
    .cq_head_valid_o (cq_head_valid_o)
  );

  req_segmenter u_seg (
    .axis_aclk_i  (axis_aclk_i),
    .axis_rstn_i  (axis_rstn_i),
    .wqe_i        (wqe_bus.dst),
    .req_valid_o  (req_valid_o),
    .req_ready_i  (req_ready_i),
    .req_opcode_o (req_opcode_o),
    .req_qpn_o    (req_qpn_o),
    .req_last_o   (req_last_o),
    .req_laddr_o  (req_laddr_o),
    .req_raddr_o  (req_raddr_o),
    .req_len_o    (req_len_o),
    .cmpl_o       (cmpl_bus.src)
  );

  resp_tracker u_track (
    .axis_aclk_i (axis_aclk_i),
    .axis_rstn_i (axis_rstn_i),
    .rx_ack_i    (rx_ack_i),
    .rx_nack_i   (rx_nack_i),
    .rx_dat_i    (rx_dat_i),
    .op_class_i  (cmpl_bus.op_class),
    .done_i      (cmpl_bus.done),
    .resp_cnt_o  (resp_cnt)
  );

  cqe_writer u_cqe (
    .axis_aclk_i (axis_aclk_i),
    .axis_rstn_i (axis_rstn_i),
    .wqe_i       (wqe_bus.dst),
    .cmpl_i      (cmpl_bus.dst),
    .resp_cnt_i  (resp_cnt),
    .aw_valid_o  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .aw_addr_o   (aw_addr_o),
    .aw_size_o   (aw_size_o),
    .w_valid_o   (w_valid_o),
    .w_ready_i   (w_ready_i),
    .w_data_o    (w_data_o),
    .w_strb_o    (w_strb_o),
    .w_last_o    (w_last_o),
    .b_valid_i   (b_valid_i),
    .b_ready_o   (b_ready_o)
  );

endmodule

//--- verif/sq_engine_checker.sv
`timescale 1ns/1ps

module sq_engine_checker
  import roce_pkg::*;
  import host_mem_pkg::*;
(
  input logic        clk_i,
  input logic        rstn_i,
  input logic        req_valid_i,
  input logic        req_ready_i,
  input logic [7:0]  req_opcode_i,
  input logic [23:0] req_qpn_i,
  input logic        req_last_i,
  input addr_t       req_laddr_i,
  input addr_t       req_raddr_i,
  input logic [31:0] req_len_i,
  input logic        aw_valid_i,
  input logic        all_sent_i,
  input logic [31:0] resp_cnt_i,
  input logic [31:0] exp_cnt_i,
  input logic        w_valid_i,
  input logic [63:0] w_strb_i,
  input logic        done_i
);

  int fail_cnt = 0;

  // Held request under back-pressure
  assert property (@(posedge clk_i) disable iff (!rstn_i)
    req_valid_i && !req_ready_i |=> req_valid_i &&
      $stable({req_opcode_i, req_qpn_i, req_last_i, req_laddr_i, req_raddr_i, req_len_i}))
    else begin
      fail_cnt++;
      $error("request changed while stalled");
    end

  assert property (@(posedge clk_i) disable iff (!rstn_i)
    $rose(aw_valid_i) |-> $past(all_sent_i && (resp_cnt_i == exp_cnt_i)))
    else begin
      fail_cnt++;
      $error("aw_valid_o raised before the response count was met");
    end

  assert property (@(posedge clk_i) disable iff (!rstn_i)
    w_valid_i |-> (w_strb_i == 64'hF))
    else begin
      fail_cnt++;
      $error("w_strb_o is not 0xF");
    end

  assert property (@(posedge clk_i) disable iff (!rstn_i)
    done_i |=> !done_i)
    else begin
      fail_cnt++;
      $error("done lasted more than one cycle");
    end

endmodule

bind sq_engine_top sq_engine_checker u_chk (
  .clk_i        (axis_aclk_i),
  .rstn_i       (axis_rstn_i),
  .req_valid_i  (req_valid_o),
  .req_ready_i  (req_ready_i),
  .req_opcode_i (req_opcode_o),
  .req_qpn_i    (req_qpn_o),
  .req_last_i   (req_last_o),
  .req_laddr_i  (req_laddr_o),
  .req_raddr_i  (req_raddr_o),
  .req_len_i    (req_len_o),
  .aw_valid_i   (aw_valid_o),
  .all_sent_i   (cmpl_bus.all_sent),
  .resp_cnt_i   (resp_cnt),
  .exp_cnt_i    (cmpl_bus.exp_cnt),
  .w_valid_i    (w_valid_o),
  .w_strb_i     (w_strb_o),
  .done_i       (cmpl_bus.done)
);

//--- verif/sq_engine_tb.sv
`timescale 1ns/1ps

module sq_engine_tb
  import roce_pkg::*;
  import host_mem_pkg::*;
;

  localparam int    timeout_cycles = 6 * 500;
  localparam addr_t sq_base  = 64'h0000_0000_8000_0000;
  localparam addr_t cq_base  = 64'h0000_0000_9000_0000;
  localparam addr_t pd_vaddr = 64'h0000_0000_1000_0000;
  localparam addr_t rem_base = 64'h0000_0000_2000_0000;
  localparam logic [2:0] sq_num = 3'd2;

  logic axis_aclk_i;
  logic axis_rstn_i;
  logic [2:0] sq_idx_i;
  logic [31:0] sq_pi_i;
  addr_t sq_base_i, cq_base_i, pd_vaddr_i;
  logic [31:0] qp_conf_i;
  logic rx_ack_i, rx_nack_i, rx_dat_i;
  logic req_valid_o, req_ready_i, req_last_o;
  rc_opcode_t req_opcode_o;
  qpn_t req_qpn_o;
  addr_t req_laddr_o, req_raddr_o;
  len_t req_len_o;
  logic ar_valid_o, ar_ready_i, r_valid_i, r_ready_o, r_last_i;
  addr_t ar_addr_o;
  logic [2:0] ar_size_o, aw_size_o;
  logic [511:0] r_data_i, w_data_o;
  logic aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, w_last_o, b_valid_i, b_ready_o;
  addr_t aw_addr_o;
  logic [63:0] w_strb_o;
  logic [39:0] cq_head_o;
  logic cq_head_valid_o;

  logic [511:0] wqe_mem [16];
  logic [7:0]   lfsr;
  int           errors;
  int           tests_run;
  int           tests_failed;
  int           cycles;
  int           resp_since_nack;
  logic         nack_mode;
  logic [31:0]  next_head;

  // Expected traffic derived from the WQEs as they are posted
  addr_t       exp_ar [$];
  addr_t       exp_aw [$];
  logic [31:0] exp_cqe [$];
  int          exp_resp [$];
  logic [7:0]  seg_op [$];
  len_t        seg_len [$];
  addr_t       seg_la [$];
  addr_t       seg_ra [$];
  logic        seg_last [$];
  logic [1:0]  resp_q [$];

  sq_engine_top #(.NUM_SQ(8)) u_dut (.*);

  initial begin
    axis_aclk_i = 1'b0;
    forever #4 axis_aclk_i = ~axis_aclk_i;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge axis_aclk_i);
      cycles++;
      if (cycles >= timeout_cycles) begin
        $display("Timeout after %0d cycles with the engine still busy", cycles);
        $display("CHECKS FAILED");
        $finish;
      end
    end
  end

  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic next_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b    = lfsr[0];
  endtask

  function automatic int error_count();
    return errors + u_dut.u_chk.fail_cnt;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    assert (got === exp)
      else begin
        errors++;
        $display("Error %s got %h expected %h", name, got, exp);
      end
  endtask

  function automatic logic [511:0] make_wqe(input logic [15:0] wr_id, input logic [7:0] op,
                                            input len_t len, input addr_t raddr);
    wqe_word_t w;
    w.raw            = '0;
    w.f.wr_id        = wr_id;
    w.f.opcode       = op;
    w.f.length       = len;
    w.f.remote_vaddr = raddr;
    return w.raw;
  endfunction

  task automatic post_wqe(input int idx, input logic [15:0] wr_id, input logic [7:0] op,
                          input len_t len);
    len_t       rem;
    len_t       l;
    addr_t      la;
    addr_t      ra;
    logic       first;
    logic       last;
    logic [7:0] st;
    int         cnt;
    wqe_mem[idx] = make_wqe(wr_id, op, len, rem_base);
    exp_ar.push_back(sq_base + addr_t'(idx) * 64);
    exp_aw.push_back(cq_base + addr_t'(idx) * 4);
    cnt = (int'(len) + 255) / 256;
    if (cnt == 0) cnt = 1;
    st  = 8'd0;
    if (op == wqe_op_read) begin
      seg_op.push_back(READ_REQUEST);
      seg_len.push_back(len);
      seg_la.push_back(pd_vaddr);
      seg_ra.push_back(rem_base);
      seg_last.push_back(1'b1);
    end else if (op == wqe_op_write || op == wqe_op_send) begin
      rem   = len;
      la    = pd_vaddr;
      ra    = (op == wqe_op_send) ? pd_vaddr : rem_base;
      first = 1'b1;
      do begin
        last = (rem <= 32'd256);
        l    = last ? rem : 32'd256;
        if (op == wqe_op_send) begin
          seg_op.push_back(first ? (last ? SEND_ONLY : SEND_FIRST) :
                                   (last ? SEND_LAST : SEND_MIDDLE));
        end else begin
          seg_op.push_back(first ? (last ? WRITE_ONLY : WRITE_FIRST) :
                                   (last ? WRITE_LAST : WRITE_MIDDLE));
        end
        seg_len.push_back(l);
        seg_la.push_back(la);
        seg_ra.push_back(ra);
        seg_last.push_back(last);
        rem   = rem - l;
        la    = la + 64'd256;
        ra    = ra + 64'd256;
        first = 1'b0;
      end while (!last);
    end else begin
      cnt = 0;
      st  = 8'd1;
    end
    exp_resp.push_back(cnt);
    exp_cqe.push_back({st, op, wr_id});
  endtask

  task automatic ring_and_wait(input int n);
    @(posedge axis_aclk_i);
    #1 sq_pi_i = sq_pi_i + 32'(n);
    repeat (n) begin
      do @(posedge axis_aclk_i); while (!cq_head_valid_o);
      next_head = next_head + 32'd1;
      assert (cq_head_o == {8'(sq_num), next_head})
        else begin
          errors++;
          $display("Error cq_head_o got %h expected %h", cq_head_o, {8'(sq_num), next_head});
        end
    end
    repeat (3) @(posedge axis_aclk_i);
    assert (seg_op.size() == 0 && exp_aw.size() == 0)
      else begin
        errors++;
        $display("Expected requests or completions never appeared");
      end
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs_now;
    errs_now = error_count();
    tests_run++;
    if (errs_now != errs_before) tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (errs_now == errs_before) ? "ok" : "bad");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Host memory with AR/R and AW/W/B
  //////////////////////////////////////////////////////////////////////

  initial begin
    addr_t a;
    logic [31:0] c;
    int r;
    forever begin
      @(posedge axis_aclk_i);
      if (ar_valid_o) begin
        a = exp_ar.size() ? exp_ar.pop_front() : '1;
        assert (ar_addr_o == a)
          else begin
            errors++;
            $display("Error ar_addr_o got %h expected %h", ar_addr_o, a);
          end
        // One 64-byte WQE per beat
        compare_value("ar_size_o", ar_size_o, 64'd6);
        #1;
        r_valid_i = 1'b1;
        r_data_i  = wqe_mem[ar_addr_o[9:6]];
        do @(posedge axis_aclk_i); while (!r_ready_o);
        #1 r_valid_i = 1'b0;
      end else if (aw_valid_o) begin
        a = exp_aw.size() ? exp_aw.pop_front() : '1;
        r = exp_resp.size() ? exp_resp.pop_front() : -1;
        assert (aw_addr_o == a)
          else begin
            errors++;
            $display("Error aw_addr_o got %h expected %h", aw_addr_o, a);
          end
        // 4-byte CQE
        compare_value("aw_size_o", aw_size_o, 64'd2);
        assert (resp_since_nack == r)
          else begin
            errors++;
            $display("Error resp_since_nack got %h expected %h", resp_since_nack, r);
          end
        resp_since_nack = 0;
        do @(posedge axis_aclk_i); while (!w_valid_o);
        c = exp_cqe.size() ? exp_cqe.pop_front() : '1;
        assert (w_data_o == 512'(c))
          else begin
            errors++;
            $display("Error w_data_o got %h expected %h", w_data_o[31:0], c);
          end
        compare_value("w_last_o", w_last_o, 64'd1);
        #1 b_valid_i = 1'b1;
        @(posedge axis_aclk_i);
        compare_value("b_ready_o", b_ready_o, 64'd1);
        #1 b_valid_i = 1'b0;
      end
    end
  end

  // Request acceptance and scoreboard
  always @(posedge axis_aclk_i) begin
    if (axis_rstn_i && req_valid_o && req_ready_i) begin
      if (seg_op.size() == 0) begin
        errors++;
        $display("A request was issued that no WQE called for");
      end else begin
        compare_value("req_opcode_o", req_opcode_o, seg_op[0]);
        compare_value("req_len_o", req_len_o, seg_len[0]);
        compare_value("req_laddr_o", req_laddr_o, seg_la[0]);
        compare_value("req_raddr_o", req_raddr_o, seg_ra[0]);
        compare_value("req_last_o", req_last_o, seg_last[0]);
        compare_value("req_qpn_o", req_qpn_o, sq_num);
        if (seg_op[0] == READ_REQUEST) begin
          repeat ((int'(seg_len[0]) + 255) / 256) resp_q.push_back(2'd3);
        end else begin
          resp_q.push_back(2'd1);
          if (nack_mode) resp_q.push_back(seg_last[0] ? 2'd1 : 2'd2);
        end
        void'(seg_op.pop_front());
        void'(seg_len.pop_front());
        void'(seg_la.pop_front());
        void'(seg_ra.pop_front());
        void'(seg_last.pop_front());
      end
    end
  end

  // Ready stalls and response gaps from one LFSR
  initial begin
    logic b0, b1, g;
    logic [1:0] kind;
    forever begin
      @(posedge axis_aclk_i);
      #1;
      rx_ack_i  = 1'b0;
      rx_nack_i = 1'b0;
      rx_dat_i  = 1'b0;
      next_bit(b0);
      next_bit(b1);
      req_ready_i = b0 | b1;
      next_bit(g);
      if (axis_rstn_i && g && resp_q.size() != 0) begin
        kind = resp_q.pop_front();
        rx_ack_i  = (kind == 2'd1);
        rx_nack_i = (kind == 2'd2);
        rx_dat_i  = (kind == 2'd3);
        resp_since_nack = (kind == 2'd2) ? 0 : resp_since_nack + 1;
      end
    end
  end

  initial begin
    int e;
    lfsr = 8'd85;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    resp_since_nack = 0;
    nack_mode = 1'b0;
    next_head = 32'd0;
    axis_rstn_i = 1'b0;
    sq_idx_i = sq_num;
    sq_pi_i = 32'd0;
    sq_base_i = sq_base;
    cq_base_i = cq_base;
    pd_vaddr_i = pd_vaddr;
    qp_conf_i = 32'h0000_0001;
    rx_ack_i = 1'b0;
    rx_nack_i = 1'b0;
    rx_dat_i = 1'b0;
    req_ready_i = 1'b0;
    ar_ready_i = 1'b1;
    r_valid_i = 1'b0;
    r_data_i = '0;
    r_last_i = 1'b1;
    aw_ready_i = 1'b1;
    w_ready_i = 1'b1;
    b_valid_i = 1'b0;
    repeat (8) @(posedge axis_aclk_i);
    #1 axis_rstn_i = 1'b1;

    e = error_count();
    post_wqe(0, 16'h1001, wqe_op_write, 32'd778);
    ring_and_wait(1);
    report_test("write of 778 bytes in four segments", e);

    e = error_count();
    post_wqe(1, 16'h1002, wqe_op_send, 32'd100);
    ring_and_wait(1);
    report_test("send only", e);

    e = error_count();
    post_wqe(2, 16'h1003, wqe_op_read, 32'd600);
    ring_and_wait(1);
    report_test("read with three data responses", e);

    e = error_count();
    post_wqe(3, 16'h1004, wqe_op_write, 32'd256);
    post_wqe(4, 16'h1005, wqe_op_send, 32'd300);
    ring_and_wait(2);
    report_test("two WQEs from one doorbell", e);

    e = error_count();
    nack_mode = 1'b1;
    post_wqe(5, 16'h1006, wqe_op_write, 32'd512);
    ring_and_wait(1);
    nack_mode = 1'b0;
    report_test("nack restarts the count", e);

    e = error_count();
    post_wqe(6, 16'h1007, 8'h07, 32'd64);
    ring_and_wait(1);
    report_test("unsupported opcode", e);

    e = error_count();
    $display("tests %0d, tests with errors %0d, errors %0d", tests_run, tests_failed, e);
    if (e == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
logic/roce_pkg.sv
logic/host_mem_pkg.sv
logic/sq_if.sv
logic/wqe_fetch.sv
logic/req_segmenter.sv
logic/resp_tracker.sv
logic/cqe_writer.sv
logic/sq_engine_top.sv
verif/sq_engine_checker.sv
verif/sq_engine_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := sq_engine_tb
FILELIST  := list.f
BUILD     := obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "test  - build with Verilator and run the simulation"
	@echo "clean - remove the build directory"
	@echo "help  - list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out=$$(./$(BUILD)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
